// ==== hw/nrx_pkg.sv ====
//--------------------------------------------------
// Shared constants for the maze racer main board
// Memory map, raster geometry and sound link sizing
//--------------------------------------------------
package nrx_pkg;

	// CPU bus
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int RAM_AW = 11;	// 2 KB work RAM

	//--------------------------------------------------
	// Memory map
	//--------------------------------------------------
	localparam logic [ADDR_W-1:0] RAM_BASE = 16'h9800;	// $9800-$9FFF
	localparam logic [ADDR_W-1:0] INP_BASE = 16'hA000;	// $A000-$AFFF, reads
	localparam logic [ADDR_W-1:0] SND_BASE = 16'hA100;	// $A100-$A17F, writes
	localparam logic [ADDR_W-1:0] LAT_BASE = 16'hA180;	// $A180-$A18F, writes

	// Low address bits ignored by each window compare
	localparam int INP_AW = 12;
	localparam int SND_AW = 7;
	localparam int LAT_AW = 4;

	// Latch page offsets
	localparam logic [LAT_AW-1:0] LAT_IE    = 4'd1;
	localparam logic [LAT_AW-1:0] LAT_LAMP0 = 4'd4;
	localparam logic [LAT_AW-1:0] LAT_LAMP1 = 4'd5;

	//--------------------------------------------------
	// Raster, in CCLK cycles and lines
	//--------------------------------------------------
	localparam int HV_W         = 9;	// Wide enough for both counters
	localparam int H_TOTAL      = 384;
	localparam int H_ACTIVE     = 288;
	localparam int V_TOTAL      = 264;
	localparam int V_ACTIVE     = 224;
	localparam int H_SYNC_START = 304;
	localparam int H_SYNC_LEN   = 32;
	localparam int V_SYNC_START = 240;
	localparam int V_SYNC_LEN   = 4;
	localparam int VBL_IRQ_LINE = 224;
	localparam int VBL_IRQ_HMAX = 8;	// Last hpos of the irq window

	// Sound link
	localparam int SND_DEPTH   = 4;	// Power of two, pointers wrap freely
	localparam int SND_CREDITS = 4;	// Sound board receive buffer
	localparam int SND_PW      = $clog2(SND_DEPTH);
	localparam int SND_CW      = $clog2(SND_CREDITS + 1);

endpackage

// ==== hw/nrx_bus_decode.sv ====
//--------------------------------------------------
// CPU bus decoder and read data merge
// Strobe qualify, region enables, registered rdata
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_bus_decode
	import nrx_pkg::*;
(
	input  logic              CCLK,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic              mreq_n,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  logic              rfsh_n,
	input  logic [DATA_W-1:0] ram_rdata,
	input  logic [DATA_W-1:0] ctr1,
	input  logic [DATA_W-1:0] ctr2,
	input  logic [DATA_W-1:0] dsw,
	input  logic [DATA_W-1:0] int_vec,
	output logic              ram_we,
	output logic [RAM_AW-1:0] ram_addr,
	output logic              lat_we,
	output logic [LAT_AW-1:0] lat_sel,
	output logic              vec_we,
	output logic              snd_push,
	output logic [DATA_W-1:0] rdata
);

	logic              mem_cyc, mem_rd, mem_wr;	// Qualified strobes
	logic              io_wr, int_ack;
	logic              in_ram, in_inp, in_snd, in_lat;
	logic [DATA_W-1:0] inp_data;
	logic              ram_sel_q;			// RAM was read last cycle
	logic [DATA_W-1:0] port_q;			// Input port or vector byte

	// Refresh cycles also pull mreq_n low, keep them out
	assign mem_cyc = ~mreq_n & rfsh_n;
	assign mem_rd  = mem_cyc & ~rd_n;
	assign mem_wr  = mem_cyc & ~wr_n;
	assign io_wr   = ~iorq_n & ~wr_n & m1_n;
	assign int_ack = ~iorq_n & ~m1_n;		// Vector fetch

	//--------------------------------------------------
	// Region compares
	//--------------------------------------------------
	assign in_ram = addr[ADDR_W-1:RAM_AW] == RAM_BASE[ADDR_W-1:RAM_AW];
	assign in_inp = addr[ADDR_W-1:INP_AW] == INP_BASE[ADDR_W-1:INP_AW];
	assign in_snd = addr[ADDR_W-1:SND_AW] == SND_BASE[ADDR_W-1:SND_AW];
	assign in_lat = addr[ADDR_W-1:LAT_AW] == LAT_BASE[ADDR_W-1:LAT_AW];

	assign ram_we   = in_ram & mem_wr;
	assign ram_addr = addr[RAM_AW-1:0];
	assign lat_we   = in_lat & mem_wr;
	assign lat_sel  = addr[LAT_AW-1:0];		// Offset within latch page
	assign vec_we   = io_wr;
	assign snd_push = in_snd & mem_wr;

	// DSW above controller 2 above controller 1
	assign inp_data = addr[8] ? dsw : (addr[7] ? ctr2 : ctr1);

	// Read source held for one cycle to line up with the RAM
	always_ff @(posedge CCLK or negedge arst_n) begin
		if (!arst_n) begin
			ram_sel_q <= 1'b0;
			port_q    <= '0;
		end else begin
			ram_sel_q <= in_ram & mem_rd;
			if (in_inp && mem_rd)
				port_q <= inp_data;
			else if (int_ack)
				port_q <= int_vec;
			else
				port_q <= '0;	// ROM, unmapped or idle
		end
	end

	assign rdata = (ram_sel_q ? ram_rdata : '0) | port_q;

endmodule

// ==== hw/nrx_ctrl_latch.sv ====
//--------------------------------------------------
// Control latch page and vblank interrupt latch
// Holds vector, irq enable, pending bit and lamps
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_ctrl_latch
	import nrx_pkg::*;
(
	input  logic              CCLK,
	input  logic              arst_n,
	input  logic              lat_we,
	input  logic [LAT_AW-1:0] lat_sel,
	input  logic              vec_we,
	input  logic [DATA_W-1:0] wdata,
	input  logic              vbl_strobe,
	output logic [DATA_W-1:0] int_vec,
	output logic              nmi_n,
	output logic [1:0]        lamp
);

	logic irq_en;		// Enable from LAT_IE
	logic irq_pend;		// Set once per frame by vblank
	logic ie_wr;

	assign ie_wr = lat_we & (lat_sel == LAT_IE);

	always_ff @(posedge CCLK or negedge arst_n) begin
		if (!arst_n) begin
			int_vec  <= '0;
			irq_en   <= 1'b0;
			irq_pend <= 1'b0;
			lamp     <= 2'b00;
		end else begin
			if (vec_we)
				int_vec <= wdata;	// I/O write loads the vector
			// Enable write also acks, and beats a same-cycle strobe
			if (ie_wr) begin
				irq_en   <= wdata[0];
				irq_pend <= 1'b0;
			end else if (vbl_strobe) begin
				irq_pend <= 1'b1;
			end
			if (lat_we && lat_sel == LAT_LAMP0)
				lamp[0] <= wdata[0];
			if (lat_we && lat_sel == LAT_LAMP1)
				lamp[1] <= wdata[0];
			// Other offsets have no latch here
		end
	end

	// Active low to the CPU
	assign nmi_n = ~(irq_pend & irq_en);

endmodule

// ==== hw/nrx_work_ram.sv ====
//--------------------------------------------------
// 2 KB CPU work RAM, single port
// Registered read, data one cycle after address
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_work_ram
	import nrx_pkg::*;
(
	input  logic              CCLK,
	input  logic              ram_we,
	input  logic [RAM_AW-1:0] ram_addr,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] ram_rdata
);

	logic [DATA_W-1:0] mem [2**RAM_AW];	// Maps to a block RAM

	always_ff @(posedge CCLK) begin
		if (ram_we)
			mem[ram_addr] <= wdata;
		ram_rdata <= mem[ram_addr];	// Old data on a write cycle
	end

endmodule

// ==== hw/nrx_hv_timing.sv ====
//--------------------------------------------------
// Raster timing generator on CCLK
// Counters, blank and sync decodes, vblank irq pulse
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_hv_timing
	import nrx_pkg::*;
(
	input  logic            CCLK,
	input  logic            arst_n,
	output logic [HV_W-1:0] hpos,
	output logic [HV_W-1:0] vpos,
	output logic            hblank,
	output logic            vblank,
	output logic            hsync,
	output logic            vsync,
	output logic            vbl_strobe
);

	logic [HV_W-1:0] h_nxt, v_nxt;
	logic            h_wrap;
	logic            win_nxt;	// Inside the irq window next cycle
	logic            win_q;

	//--------------------------------------------------
	// Next counts
	//--------------------------------------------------
	always_comb begin
		h_wrap = (hpos == HV_W'(H_TOTAL - 1));
		h_nxt  = h_wrap ? '0 : hpos + 1'b1;
		v_nxt  = vpos;
		if (h_wrap)
			v_nxt = (vpos == HV_W'(V_TOTAL - 1)) ? '0 : vpos + 1'b1;
		win_nxt = (v_nxt == HV_W'(VBL_IRQ_LINE)) && (h_nxt <= HV_W'(VBL_IRQ_HMAX));
	end

	// Decodes use the next count so they line up with hpos/vpos
	always_ff @(posedge CCLK or negedge arst_n) begin
		if (!arst_n) begin
			hpos       <= '0;
			vpos       <= '0;
			hblank     <= 1'b0;
			vblank     <= 1'b0;
			hsync      <= 1'b1;
			vsync      <= 1'b1;
			win_q      <= 1'b0;
			vbl_strobe <= 1'b0;
		end else begin
			hpos   <= h_nxt;
			vpos   <= v_nxt;
			hblank <= h_nxt >= HV_W'(H_ACTIVE);
			vblank <= v_nxt >= HV_W'(V_ACTIVE);
			hsync  <= ~((h_nxt >= HV_W'(H_SYNC_START)) &&
				(h_nxt < HV_W'(H_SYNC_START + H_SYNC_LEN)));	// Active low
			vsync  <= ~((v_nxt >= HV_W'(V_SYNC_START)) &&
				(v_nxt < HV_W'(V_SYNC_START + V_SYNC_LEN)));
			win_q  <= win_nxt;
			// Rising edge of the window, one set event per frame
			vbl_strobe <= win_nxt & ~win_q;
		end
	end

endmodule

// ==== hw/nrx_sound_link.sv ====
//--------------------------------------------------
// Sound command queue with credit flow control
// CPU writes queue up, one credit spent per byte sent
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_sound_link
	import nrx_pkg::*;
(
	input  logic              CCLK,
	input  logic              arst_n,
	input  logic              snd_push,
	input  logic [DATA_W-1:0] wdata,
	input  logic              snd_credit,
	output logic              snd_valid,
	output logic [DATA_W-1:0] snd_data,
	output logic              snd_overrun
);

	logic [DATA_W-1:0] q_mem [SND_DEPTH];	// Payload, no reset
	logic [SND_PW-1:0] wr_ptr, rd_ptr;
	logic [SND_PW:0]   q_cnt;		// 0..SND_DEPTH
	logic [SND_CW-1:0] credits;		// Free slots on the sound board
	logic              q_full, q_empty;
	logic              push_ok, send;

	assign q_full  = (q_cnt == (SND_PW+1)'(SND_DEPTH));
	assign q_empty = (q_cnt == '0);
	assign push_ok = snd_push & ~q_full;
	assign send    = ~q_empty & (credits != '0);

	// Head of queue is presented straight from the registers
	assign snd_valid = send;
	assign snd_data  = q_mem[rd_ptr];

	always_ff @(posedge CCLK) begin
		if (push_ok)
			q_mem[wr_ptr] <= wdata;
	end

	//--------------------------------------------------
	// Pointers, fill count, credits, overrun
	//--------------------------------------------------
	always_ff @(posedge CCLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			q_cnt       <= '0;
			credits     <= SND_CW'(SND_CREDITS);
			snd_overrun <= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, send})
				2'b10:   q_cnt <= q_cnt + 1'b1;
				2'b01:   q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;	// Both or neither
			endcase
			// Send and return together leave the count alone
			if (send && !snd_credit)
				credits <= credits - 1'b1;
			else if (!send && snd_credit && credits != SND_CW'(SND_CREDITS))
				credits <= credits + 1'b1;
			if (snd_push && q_full)
				snd_overrun <= 1'b1;	// Sticky until reset
		end
	end

endmodule

// ==== hw/nrx_main_bus.sv ====
//--------------------------------------------------
// Main board glue, top level
// CPU bus in, lamps, nmi, video timing, sound link out
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_main_bus
	import nrx_pkg::*;
(
	input  logic              CCLK,
	input  logic              arst_n,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	input  logic              mreq_n,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              m1_n,
	input  logic              rfsh_n,
	input  logic [DATA_W-1:0] ctr1,		// Controllers, active low
	input  logic [DATA_W-1:0] ctr2,
	input  logic [DATA_W-1:0] dsw,
	input  logic              snd_credit,
	output logic [DATA_W-1:0] rdata,
	output logic              nmi_n,
	output logic [1:0]        lamp,
	output logic              hsync,
	output logic              vsync,
	output logic              hblank,
	output logic              vblank,
	output logic              snd_valid,
	output logic [DATA_W-1:0] snd_data,
	output logic              snd_overrun
);

	logic              ram_we;
	logic [RAM_AW-1:0] ram_addr;
	logic [DATA_W-1:0] ram_rdata;
	logic              lat_we;
	logic [LAT_AW-1:0] lat_sel;
	logic              vec_we;
	logic [DATA_W-1:0] int_vec;
	logic              snd_push;
	logic              vbl_strobe;

	//--------------------------------------------------
	// CPU side
	//--------------------------------------------------
	nrx_bus_decode u_bus_decode (
		.CCLK      (CCLK),
		.arst_n    (arst_n),
		.addr      (addr),
		.mreq_n    (mreq_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.rfsh_n    (rfsh_n),
		.ram_rdata (ram_rdata),
		.ctr1      (ctr1),
		.ctr2      (ctr2),
		.dsw       (dsw),
		.int_vec   (int_vec),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.lat_we    (lat_we),
		.lat_sel   (lat_sel),
		.vec_we    (vec_we),
		.snd_push  (snd_push),
		.rdata     (rdata)
	);

	nrx_work_ram u_work_ram (
		.CCLK      (CCLK),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.wdata     (wdata),
		.ram_rdata (ram_rdata)
	);

	nrx_ctrl_latch u_ctrl_latch (
		.CCLK       (CCLK),
		.arst_n     (arst_n),
		.lat_we     (lat_we),
		.lat_sel    (lat_sel),
		.vec_we     (vec_we),
		.wdata      (wdata),
		.vbl_strobe (vbl_strobe),
		.int_vec    (int_vec),
		.nmi_n      (nmi_n),
		.lamp       (lamp)
	);

	// Beam position only feeds the video side, not built here
	nrx_hv_timing u_hv_timing (
		.CCLK       (CCLK),
		.arst_n     (arst_n),
		.hpos       (),
		.vpos       (),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync      (hsync),
		.vsync      (vsync),
		.vbl_strobe (vbl_strobe)
	);

	nrx_sound_link u_sound_link (
		.CCLK        (CCLK),
		.arst_n      (arst_n),
		.snd_push    (snd_push),
		.wdata       (wdata),
		.snd_credit  (snd_credit),
		.snd_valid   (snd_valid),
		.snd_data    (snd_data),
		.snd_overrun (snd_overrun)
	);

endmodule

// ==== test/nrx_clk_gen.sv ====
//--------------------------------------------------
// Testbench clock and reset source
// 8 ns CCLK, arst_n held low for 16 cycles
//--------------------------------------------------
`timescale 1ns/1ps

module nrx_clk_gen (
	output logic CCLK,
	output logic arst_n
);

	localparam int HALF_NS    = 4;	// 8 ns period
	localparam int RST_CYCLES = 16;

	initial begin
		CCLK = 1'b0;
		forever #(HALF_NS) CCLK = ~CCLK;
	end

	// Release away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge CCLK);
		@(negedge CCLK);
		arst_n = 1'b1;
	end

endmodule

// ==== test/tb_nrx_main_bus.sv ====
//--------------------------------------------------
// Testbench for the main board glue
// Table of CPU bus cycles, sound board model, checks
//--------------------------------------------------
`timescale 1ns/1ps

module tb_nrx_main_bus
	import nrx_pkg::*;
();

	// Entry kinds, bus cycles first, then control steps
	localparam logic [3:0] K_IDLE = 4'd0, K_MRD = 4'd1, K_MWR = 4'd2, K_IOWR = 4'd3,
		K_ACK = 4'd4, K_RFSH = 4'd5, K_HOLD = 4'd6, K_FREE = 4'd7, K_DRAIN = 4'd8,
		K_VBL = 4'd9, K_OVR = 4'd10;
	localparam int SEED = 11574;
	localparam logic [7:0] CTR1_V = 8'hFE;
	localparam logic [7:0] CTR2_V = 8'hBD;
	localparam logic [7:0] DSW_V  = 8'h35;

	typedef struct packed {
		logic [3:0]  kind;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;	// rdata, or overrun level for K_OVR
		logic        keep;	// Sound byte must reach the board
	} op_t;

	logic              CCLK, arst_n;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata, ctr1, ctr2, dsw, rdata, snd_data;
	logic              mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n, snd_credit;
	logic              nmi_n, hsync, vsync, hblank, vblank, snd_valid, snd_overrun;
	logic [1:0]        lamp;

	op_t         tbl[$];
	logic [7:0]  ram_model [2**RAM_AW];	// Last byte written per offset
	logic [15:0] ram_used[$];
	logic [7:0]  snd_exp[$];		// Bytes still owed to the board
	int          ret_due[$];		// Cycle at which each credit goes back
	int          cyc = 0, outstanding = 0, seed_init, dummy;
	bit          hold_credits = 0, tbl_ready = 0;
	bit          m_en = 0, m_pend = 0;	// Interrupt model
	logic [1:0]  m_lamp = 2'b00;
	int          err_rd = 0, err_lat = 0, err_snd = 0, err_vid = 0;
	int          hb_cnt = 0, vb_lines = 0, frames = 0;
	int          hs_cnt = 0, vs_lines = 0;
	logic        hb_q = 1'b0, vb_q = 1'b0, vs_q = 1'b1;

	nrx_clk_gen u_clk_gen (.CCLK(CCLK), .arst_n(arst_n));
	nrx_main_bus u_nrx_main_bus (.*);

	//--------------------------------------------------
	// Table building
	//--------------------------------------------------
	task automatic add_op(input logic [3:0] k, input logic [15:0] a, input logic [7:0] d,
		input logic [7:0] e, input logic keep);
		tbl.push_back({k, a, d, e, keep});
	endtask

	task automatic ram_write(input logic [15:0] a, input logic [7:0] d);
		add_op(K_MWR, a, d, 8'h00, 1'b0);
		ram_model[a[RAM_AW-1:0]] = d;
		ram_used.push_back(a);
	endtask

	task automatic ram_read(input logic [15:0] a);
		add_op(K_MRD, a, 8'h00, ram_model[a[RAM_AW-1:0]], 1'b0);
	endtask

	task automatic build_table();
		logic [15:0] a;
		ram_write(16'h9800, 8'h5A);
		ram_read(16'h9800);
		ram_write(16'h9FFF, 8'hA5);	// Top of the window
		ram_read(16'h9FFF);
		ram_write(16'h9800, 8'h3C);
		ram_read(16'h9800);
		add_op(K_RFSH, 16'h9800, 8'h00, 8'h00, 1'b0);	// Refresh with rd_n low, no data
		repeat (24) begin
			a = RAM_BASE + 16'($urandom % 2048);
			ram_write(a, 8'($urandom));
			ram_read(ram_used[$urandom % ram_used.size()]);
		end
		foreach (ram_used[j]) ram_read(ram_used[j]);
		// ROM and holes read as zero
		add_op(K_MRD, 16'h0000, 8'h00, 8'h00, 1'b0);
		add_op(K_MRD, 16'h3FFF, 8'h00, 8'h00, 1'b0);
		add_op(K_MRD, 16'h97FF, 8'h00, 8'h00, 1'b0);
		add_op(K_MRD, 16'hC000, 8'h00, 8'h00, 1'b0);
		add_op(K_IDLE, 16'h9800, 8'h00, 8'h00, 1'b0);
		add_op(K_MRD, INP_BASE, 8'h00, CTR1_V, 1'b0);
		add_op(K_MRD, 16'hA080, 8'h00, CTR2_V, 1'b0);
		add_op(K_MRD, 16'hA100, 8'h00, DSW_V, 1'b0);
		add_op(K_MWR, LAT_BASE + LAT_LAMP0, 8'h01, 8'h00, 1'b0);
		add_op(K_MWR, LAT_BASE + LAT_LAMP1, 8'hFF, 8'h00, 1'b0);
		add_op(K_MWR, LAT_BASE + LAT_LAMP0, 8'hFE, 8'h00, 1'b0);	// Bit 0 only
		add_op(K_MWR, LAT_BASE + 16'd2, 8'h01, 8'h00, 1'b0);	// Unused offset
		add_op(K_IOWR, 16'h0038, 8'hCF, 8'h00, 1'b0);
		add_op(K_ACK, 16'h0000, 8'h00, 8'hCF, 1'b0);
		add_op(K_IOWR, 16'h0000, 8'hD7, 8'h00, 1'b0);
		add_op(K_ACK, 16'h0000, 8'h00, 8'hD7, 1'b0);
		// Sound stream, more bytes than credits
		for (int i = 0; i < 8; i++)
			add_op(K_MWR, SND_BASE + 16'(i * 17 % 128), 8'h10 + 8'(i), 8'h00, 1'b1);
		add_op(K_DRAIN, 16'h0, 8'h0, 8'h00, 1'b0);
		add_op(K_OVR, 16'h0, 8'h0, 8'h00, 1'b0);
		// Credits withheld, then DEPTH+1 burst
		add_op(K_HOLD, 16'h0, 8'h0, 8'h00, 1'b0);
		for (int i = 0; i < SND_CREDITS + SND_DEPTH + 1; i++)
			add_op(K_MWR, SND_BASE + 16'(i), 8'hC0 + 8'(i), 8'h00,
				i < SND_CREDITS + SND_DEPTH);
		add_op(K_OVR, 16'h0, 8'h0, 8'h01, 1'b0);
		add_op(K_FREE, 16'h0, 8'h0, 8'h00, 1'b0);
		add_op(K_DRAIN, 16'h0, 8'h0, 8'h00, 1'b0);
		add_op(K_OVR, 16'h0, 8'h0, 8'h01, 1'b0);	// Sticky
		// Vblank interrupt on, ack, then off
		add_op(K_MWR, LAT_BASE + LAT_IE, 8'h01, 8'h00, 1'b0);
		add_op(K_VBL, 16'h0, 8'h0, 8'h00, 1'b0);
		ram_read(16'h9800);
		add_op(K_MWR, LAT_BASE + LAT_IE, 8'h01, 8'h00, 1'b0);
		add_op(K_MWR, LAT_BASE + LAT_IE, 8'h00, 8'h00, 1'b0);
		add_op(K_VBL, 16'h0, 8'h0, 8'h00, 1'b0);
	endtask

	//--------------------------------------------------
	// Bus master
	//--------------------------------------------------
	task automatic bus_idle();
		mreq_n <= 1'b1;
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		m1_n   <= 1'b1;
		rfsh_n <= 1'b1;
	endtask

	// Strobes for one cycle, rdata checked half a cycle after they are taken
	task automatic drive_cycle(input op_t op);
		@(posedge CCLK);
		addr   <= op.addr;
		wdata  <= op.data;
		mreq_n <= !(op.kind == K_MRD || op.kind == K_MWR || op.kind == K_RFSH);
		iorq_n <= !(op.kind == K_IOWR || op.kind == K_ACK);
		rd_n   <= !(op.kind == K_MRD || op.kind == K_RFSH);
		wr_n   <= !(op.kind == K_MWR || op.kind == K_IOWR);
		m1_n   <= (op.kind != K_ACK);
		rfsh_n <= (op.kind != K_RFSH);
		@(posedge CCLK);
		bus_idle();
		@(negedge CCLK);
	endtask

	task automatic print_counts();
		$display("Check summary: rdata %0d, latch %0d, sound %0d, video %0d errors",
			err_rd, err_lat, err_snd, err_vid);
	endtask

	initial begin
		op_t op;
		seed_init = $urandom(SEED);
		addr       = '0;
		wdata      = '0;
		ctr1       = CTR1_V;
		ctr2       = CTR2_V;
		dsw        = DSW_V;
		snd_credit = 1'b0;
		bus_idle();
		build_table();
		tbl_ready = 1'b1;
		wait (arst_n === 1'b1);
		foreach (tbl[i]) begin
			op = tbl[i];
			case (op.kind)
				K_HOLD:  hold_credits = 1'b1;
				K_FREE:  hold_credits = 1'b0;
				K_DRAIN: while (snd_exp.size() != 0 || outstanding != 0) @(negedge CCLK);
				K_OVR: assert (snd_overrun === op.exp[0]) else begin
					$display("Error at %0t ns: snd_overrun %b, expected %b",
						$time, snd_overrun, op.exp[0]);
					err_snd++;
				end
				K_VBL: begin
					@(posedge vblank);
					repeat (4) @(negedge CCLK);
					m_pend = 1'b1;	// One set event per frame
				end
				default: begin
					// Owed before the strobes, the byte can leave right after
					if (op.kind == K_MWR && op.keep)
						snd_exp.push_back(op.data);
					drive_cycle(op);
					assert (rdata === op.exp) else begin
						$display("Error at %0t ns: rdata %h at %h (kind %0d), expected %h",
							$time, rdata, op.addr, op.kind, op.exp);
						err_rd++;
					end
					if (op.kind == K_MWR && op.addr == LAT_BASE + LAT_IE) begin
						m_en   = op.data[0];
						m_pend = 1'b0;	// Enable write also acks
					end
					if (op.kind == K_MWR && op.addr == LAT_BASE + LAT_LAMP0)
						m_lamp[0] = op.data[0];
					if (op.kind == K_MWR && op.addr == LAT_BASE + LAT_LAMP1)
						m_lamp[1] = op.data[0];
				end
			endcase
			assert (lamp === m_lamp && nmi_n === !(m_en && m_pend)) else begin
				$display("Error at %0t ns: lamp %b nmi_n %b, expected lamp %b nmi_n %b",
					$time, lamp, nmi_n, m_lamp, !(m_en && m_pend));
				err_lat++;
			end
		end
		wait (frames >= 1);	// At least one whole frame measured
		print_counts();
		if (err_rd + err_lat + err_snd + err_vid == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	//--------------------------------------------------
	// Sound board model
	//--------------------------------------------------
	always @(negedge CCLK) begin
		if (arst_n) begin
			if (snd_valid) begin
				outstanding++;
				assert (outstanding <= SND_CREDITS) else begin
					$display("Error at %0t ns: %0d bytes outstanding", $time, outstanding);
					err_snd++;
				end
				assert (snd_exp.size() != 0 && snd_data === snd_exp[0]) else begin
					$display("Error at %0t ns: sound byte %h out of order or unexpected",
						$time, snd_data);
					err_snd++;
				end
				if (snd_exp.size() != 0)
					dummy = snd_exp.pop_front();
				ret_due.push_back(cyc + 1 + int'($urandom % 8));	// Board busy a while
			end
			if (snd_credit)
				outstanding--;
		end
	end

	always @(posedge CCLK) begin
		cyc = cyc + 1;
		if (arst_n && !hold_credits && ret_due.size() != 0 && ret_due[0] <= cyc) begin
			snd_credit <= 1'b1;	// One credit per pulse
			dummy = ret_due.pop_front();
		end else
			snd_credit <= 1'b0;
	end

	// Blanking and sync lengths, line by line and frame by frame
	always @(negedge CCLK) begin
		if (arst_n) begin
			if (hblank)
				hb_cnt++;
			if (!hsync)
				hs_cnt++;
			if (hb_q && !hblank) begin
				assert (hb_cnt == H_TOTAL - H_ACTIVE) else begin
					$display("Error at %0t ns: %0d hblank cycles in a line", $time, hb_cnt);
					err_vid++;
				end
				assert (hs_cnt == H_SYNC_LEN) else begin
					$display("Error at %0t ns: %0d hsync cycles in a line", $time, hs_cnt);
					err_vid++;
				end
				hb_cnt = 0;
				hs_cnt = 0;
				if (vb_q)
					vb_lines++;
				if (!vs_q)
					vs_lines++;
				if (vb_q && !vblank) begin	// Frame ends with the last line
					assert (vb_lines == V_TOTAL - V_ACTIVE) else begin
						$display("Error at %0t ns: %0d vblank lines", $time, vb_lines);
						err_vid++;
					end
					assert (vs_lines == V_SYNC_LEN) else begin
						$display("Error at %0t ns: %0d vsync lines", $time, vs_lines);
						err_vid++;
					end
					vb_lines = 0;
					vs_lines = 0;
					frames++;
				end
			end
			hb_q = hblank;
			vb_q = vblank;
			vs_q = vsync;
		end
	end

	// Watchdog, two frames plus four cycles per entry
	initial begin
		wait (tbl_ready);
		repeat (2 * H_TOTAL * V_TOTAL + 4 * tbl.size() + 16) @(posedge CCLK);
		$display("Watchdog expired, the tests did not finish in time");
		print_counts();
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== nrx_main_bus.f ====
hw/nrx_pkg.sv
hw/nrx_bus_decode.sv
hw/nrx_ctrl_latch.sv
hw/nrx_work_ram.sv
hw/nrx_hv_timing.sv
hw/nrx_sound_link.sv
hw/nrx_main_bus.sv
test/nrx_clk_gen.sv
test/tb_nrx_main_bus.sv
